//--- verification/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;

	import mipsPkg::*;

	localparam logic [31:0] resetVec = 32'h0000_0000;
	localparam int timeoutCycles = 2000;
	localparam int memWords = 256;

	logic cclk;
	logic rstb;
	logic [31:0] memRdata;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic memWrite;

	logic [31:0] mem [memWords];
	logic [31:0] addrQ [$];
	logic [31:0] dataQ [$];
	int pcIdx;

	mipsCore #(
		.resetVector(resetVec)
	) dut0 (
		.cclk(cclk),
		.rstb(rstb),
		.memRdata(memRdata),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memWrite(memWrite)
	);

	bind controlUnit mipsCoreAsserts asserts0 (
		.cclk(cclk),
		.rstb(rstb),
		.state(state),
		.memWrite(memWrite),
		.regWrite(regWrite),
		.irWrite(irWrite)
	);

	initial begin
		cclk = 1'b0;
		forever #4 cclk = ~cclk;
	end

	// Word addressed unified memory
	assign memRdata = mem[memAddr[9:2]];

	always @(posedge cclk) begin
		if (memWrite === 1'b1) begin
			mem[memAddr[9:2]] <= memWdata;
		end
	end

	// Record each store strobe mid cycle
	always @(negedge cclk) begin
		if (rstb === 1'b1 && memWrite === 1'b1) begin
			addrQ.push_back(memAddr);
			dataQ.push_back(memWdata);
		end
	end

	function automatic logic [31:0] rType(functT fn, int rs, int rt, int rd, int sh);
		return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic logic [31:0] iType(opcodeT op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jType(opcodeT op, int target);
		return {op, 26'(target)};
	endfunction

	function automatic logic [31:0] signExt(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic emit(logic [31:0] word);
		mem[pcIdx] = word;
		pcIdx++;
	endtask

	task automatic checkValue(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp);
			$display("Something failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic checkStore(string name, int k, logic [31:0] expAddr, logic [31:0] expData);
		checkValue($sformatf("%s store %0d address", name, k), addrQ[k], expAddr);
		checkValue($sformatf("%s store %0d data", name, k), dataQ[k], expData);
	endtask

	// Core held in reset while the memory is rewritten
	task automatic holdReset();
		int i;
		@(posedge cclk);
		rstb <= 1'b0;
		@(posedge cclk);
		for (i = 0; i < memWords; i++) begin
			mem[i] = {8'hfc, 8'(i), ~8'(i), 8'(i)};
		end
		pcIdx = 0;
	endtask

	task automatic runProgram(int stores, string name);
		int cycles;
		repeat (9) @(posedge cclk);
		addrQ.delete();
		dataQ.delete();
		rstb <= 1'b1;
		cycles = 0;
		while (addrQ.size() < stores && cycles < timeoutCycles) begin
			@(posedge cclk);
			cycles++;
		end
		if (addrQ.size() < stores) begin
			$display("Timeout in %s test: saw %0d of %0d stores", name, addrQ.size(), stores);
			$display("Something failed");
			$fatal(1, "store wait timed out");
		end
	endtask

	task automatic testRtype();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expVals [7];
		functT ops [7];
		int k;
		a = $urandom();
		b = $urandom();
		ops = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt};
		expVals[0] = a + b;
		expVals[1] = a - b;
		expVals[2] = a & b;
		expVals[3] = a | b;
		expVals[4] = a ^ b;
		expVals[5] = ~(a | b);
		expVals[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		holdReset();
		mem[64] = a;
		mem[65] = b;
		emit(iType(opLw, 0, 1, 16'h0100));
		emit(iType(opLw, 0, 2, 16'h0104));
		for (k = 0; k < 7; k++) begin
			emit(rType(ops[k], 1, 2, 3, 0));
			emit(iType(opSw, 0, 3, 16'(32'h200 + 4 * k)));
		end
		emit(jType(opJ, pcIdx));
		runProgram(7, "rtype");
		for (k = 0; k < 7; k++) begin
			checkStore("rtype", k, 32'h200 + 4 * k, expVals[k]);
		end
	endtask

	task automatic testShiftImm();
		logic [31:0] x;
		logic [31:0] ops [10];
		logic [31:0] expVals [10];
		int k;
		// Negative operand so sra differs from srl
		x = $urandom() | 32'h8000_0000;
		ops[0] = rType(fnSll, 0, 1, 3, 7);
		ops[1] = rType(fnSrl, 0, 1, 3, 5);
		ops[2] = rType(fnSra, 0, 1, 3, 9);
		ops[3] = iType(opAddi, 1, 3, 16'hfed4);
		ops[4] = iType(opSlti, 1, 3, 16'hfffb);
		ops[5] = iType(opSlti, 0, 3, 16'hfffb);
		ops[6] = iType(opAndi, 1, 3, 16'h8f0f);
		ops[7] = iType(opOri, 1, 3, 16'hc0a5);
		ops[8] = iType(opXori, 1, 3, 16'hf00f);
		ops[9] = iType(opLui, 0, 3, 16'h9abc);
		expVals[0] = x << 7;
		expVals[1] = x >> 5;
		expVals[2] = $signed(x) >>> 9;
		expVals[3] = x + signExt(16'hfed4);
		expVals[4] = ($signed(x) < $signed(signExt(16'hfffb))) ? 32'd1 : 32'd0;
		expVals[5] = ($signed(32'd0) < $signed(signExt(16'hfffb))) ? 32'd1 : 32'd0;
		expVals[6] = x & {16'h0000, 16'h8f0f};
		expVals[7] = x | {16'h0000, 16'hc0a5};
		expVals[8] = x ^ {16'h0000, 16'hf00f};
		expVals[9] = {16'h9abc, 16'h0000};
		holdReset();
		mem[64] = x;
		emit(iType(opLw, 0, 1, 16'h0100));
		for (k = 0; k < 10; k++) begin
			emit(ops[k]);
			emit(iType(opSw, 0, 3, 16'(32'h200 + 4 * k)));
		end
		emit(jType(opJ, pcIdx));
		runProgram(10, "shift and immediate");
		for (k = 0; k < 10; k++) begin
			checkStore("shift and immediate", k, 32'h200 + 4 * k, expVals[k]);
		end
	endtask

	task automatic testBranches();
		logic [31:0] a;
		a = $urandom();
		holdReset();
		mem[64] = a;
		mem[65] = a ^ 32'h0000_0010;
		emit(iType(opLw, 0, 1, 16'h0100));
		emit(iType(opLw, 0, 2, 16'h0100));
		emit(iType(opLw, 0, 3, 16'h0104));
		// beq taken over two words
		emit(iType(opBeq, 1, 2, 16'd2));
		emit(iType(opAddi, 0, 5, 16'h0011));
		emit(iType(opSw, 0, 5, 16'h0200));
		emit(iType(opAddi, 0, 5, 16'h0022));
		emit(iType(opSw, 0, 5, 16'h0200));
		// beq falls through
		emit(iType(opBeq, 1, 3, 16'd2));
		emit(iType(opAddi, 0, 5, 16'h0033));
		emit(iType(opSw, 0, 5, 16'h0204));
		// bne taken
		emit(iType(opBne, 1, 3, 16'd2));
		emit(iType(opAddi, 0, 5, 16'h0044));
		emit(iType(opSw, 0, 5, 16'h0208));
		emit(iType(opAddi, 0, 5, 16'h0055));
		emit(iType(opSw, 0, 5, 16'h020c));
		// bne falls through
		emit(iType(opBne, 1, 2, 16'd2));
		emit(iType(opAddi, 0, 5, 16'h0066));
		emit(iType(opSw, 0, 5, 16'h0210));
		emit(jType(opJ, pcIdx));
		runProgram(4, "branch");
		checkStore("branch", 0, 32'h200, 32'h22);
		checkStore("branch", 1, 32'h204, 32'h33);
		checkStore("branch", 2, 32'h20c, 32'h55);
		checkStore("branch", 3, 32'h210, 32'h66);
	endtask

	task automatic testJumps();
		int jalIdx;
		logic [31:0] retAddr;
		holdReset();
		emit(iType(opAddi, 0, 5, 16'h0077));
		emit(jType(opJ, 3));
		emit(iType(opSw, 0, 5, 16'h02f0));
		jalIdx = pcIdx;
		emit(jType(opJal, 7));
		emit(iType(opAddi, 0, 5, 16'h0099));
		emit(iType(opSw, 0, 5, 16'h0208));
		emit(jType(opJ, 6));
		// Subroutine at word 7
		emit(iType(opSw, 0, 31, 16'h0200));
		emit(iType(opSw, 0, 5, 16'h0204));
		emit(rType(fnJr, 31, 0, 0, 0));
		retAddr = resetVec + 32'(4 * (jalIdx + 1));
		runProgram(3, "jump");
		checkStore("jump", 0, 32'h200, retAddr);
		checkStore("jump", 1, 32'h204, 32'h77);
		checkStore("jump", 2, 32'h208, 32'h99);
	endtask

	task automatic testRegZero();
		logic [31:0] x;
		logic [31:0] base;
		x = $urandom();
		base = 32'h180 + (($urandom() % 32) << 2);
		holdReset();
		mem[64] = x;
		emit(iType(opLw, 0, 1, 16'h0100));
		// Both writes to r0 must be dropped
		emit(iType(opAddi, 1, 0, 16'h0005));
		emit(rType(fnAdd, 1, 1, 0, 0));
		emit(iType(opSw, 0, 0, 16'h0200));
		emit(iType(opAddi, 0, 6, base[15:0]));
		emit(iType(opSw, 6, 1, 16'h0040));
		emit(iType(opSw, 6, 1, 16'hfff8));
		emit(jType(opJ, pcIdx));
		runProgram(3, "register zero");
		checkStore("register zero", 0, 32'h200, 32'h0);
		checkStore("register zero", 1, base + signExt(16'h0040), x);
		checkStore("register zero", 2, base + signExt(16'hfff8), x);
	endtask

	initial begin
		rstb = 1'b0;
		pcIdx = 0;
		void'($urandom(74));
		testRtype();
		testShiftImm();
		testBranches();
		testJumps();
		testRegZero();
		if (dut0.ctrl0.asserts0.failCount == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "assertion failures during the run");
		end
	end

endmodule

`default_nettype wire

//--- verification/mipsCore_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAsserts (
	input logic cclk,
	input logic rstb,
	input mipsPkg::ctrlState state,
	input logic memWrite,
	input logic regWrite,
	input logic irWrite
);

	import mipsPkg::*;

	// Failed assertion count
	int failCount = 0;

	noStoreWithRegWrite: assert property (@(posedge cclk) disable iff (!rstb)
		!(memWrite && regWrite))
	else begin
		failCount++;
		$error("memWrite and regWrite high in the same cycle");
	end

	singleCycleStrobe: assert property (@(posedge cclk) disable iff (!rstb)
		memWrite |=> !memWrite)
	else begin
		failCount++;
		$error("memWrite high for two cycles in a row");
	end

	irWriteInFetch: assert property (@(posedge cclk) disable iff (!rstb)
		irWrite |-> state == stFetch)
	else begin
		failCount++;
		$error("irWrite high outside the fetch state");
	end

	// Reset must leave the store strobe low
	quietAfterReset: assert property (@(posedge cclk) !rstb |=> !memWrite)
	else begin
		failCount++;
		$error("memWrite high right after a reset cycle");
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/mipsPkg.sv
verilog/aluDecoder.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/mipsCore.sv
verification/mipsCore_asserts.sv
verification/mipsCoreTb.sv

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input logic [mipsPkg::dataWidth-1:0] a,
	input logic [mipsPkg::dataWidth-1:0] b,
	input logic [4:0] shamt,
	input mipsPkg::aluCtrlT aluControl,
	output logic [mipsPkg::dataWidth-1:0] result,
	output logic zero
);

	import mipsPkg::*;

	logic lessThan;

	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluControl)
			acAdd: result = a + b;
			acSub: result = a - b;
			acAnd: result = a & b;
			acOr: result = a | b;
			acXor: result = a ^ b;
			acNor: result = ~(a | b);
			acSlt: result = {{(dataWidth - 1){1'b0}}, lessThan};
			// Shifts act on the rt operand
			acSll: result = b << shamt;
			acSrl: result = b >> shamt;
			acSra: result = $signed(b) >>> shamt;
			acLui: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	// Drives the beq/bne decision
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- verilog/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
	input mipsPkg::aluOpT aluOp,
	input logic [5:0] code,
	output mipsPkg::aluCtrlT aluControl
);

	import mipsPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: aluControl = acAdd;
			aluSub: aluControl = acSub;
			aluFunct: begin
				case (code)
					fnAdd: aluControl = acAdd;
					fnSub: aluControl = acSub;
					fnAnd: aluControl = acAnd;
					fnOr: aluControl = acOr;
					fnXor: aluControl = acXor;
					fnNor: aluControl = acNor;
					fnSlt: aluControl = acSlt;
					fnSll: aluControl = acSll;
					fnSrl: aluControl = acSrl;
					fnSra: aluControl = acSra;
					// jr and unknown codes
					default: aluControl = acAdd;
				endcase
			end
			default: begin
				case (code)
					opSlti: aluControl = acSlt;
					opAndi: aluControl = acAnd;
					opOri: aluControl = acOr;
					opXori: aluControl = acXor;
					opLui: aluControl = acLui;
					default: aluControl = acAdd;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic cclk,
	input logic rstb,
	input logic [mipsPkg::dataWidth-1:0] instr,
	output logic memtoReg,
	output logic iorD,
	output logic [1:0] regDst,
	output logic [1:0] pcSrc,
	output logic [1:0] aluSrcA,
	output logic [1:0] aluSrcB,
	// Bit 0 for beq, bit 1 for bne
	output logic [1:0] branch,
	output logic irWrite,
	output logic memWrite,
	output logic pcWrite,
	output logic regWrite,
	output logic extOp,
	output mipsPkg::aluCtrlT aluControl
);

	import mipsPkg::*;

	ctrlState state;
	ctrlState nextState;
	opcodeT opcode;
	functT funct;
	aluOpT aluOp;
	logic [5:0] decCode;
	logic isShift;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct = functT'(instr[5:0]);
	assign isShift = (funct == fnSll) || (funct == fnSrl) || (funct == fnSra);

	// I-type states decode on the opcode, everything else on funct
	assign decCode = (state == stItypeExecute || state == stItypeWriteback) ?
		instr[31:26] : instr[5:0];

	aluDecoder aluDec0 (
		.aluOp(aluOp),
		.code(decCode),
		.aluControl(aluControl)
	);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stFetch;
		case (state)
			stFetch: nextState = stDecode;
			stDecode: begin
				case (opcode)
					opLw, opSw: nextState = stMemAdr;
					opRtype: nextState = stExecute;
					opBeq, opBne: nextState = stBranch;
					opAddi, opSlti, opAndi, opOri, opXori, opLui: nextState = stItypeExecute;
					opJ: nextState = stJump;
					opJal: nextState = stJal;
					default: nextState = stFetch;
				endcase
			end
			stMemAdr: nextState = (opcode == opLw) ? stMemRead : stMemWrite;
			stMemRead: nextState = stMemWriteback;
			stExecute: nextState = (funct == fnJr) ? stJr : stAluWriteback;
			stItypeExecute: nextState = stItypeWriteback;
			default: nextState = stFetch;
		endcase
	end

	always_comb begin
		// Enables low and sign extension unless a state says otherwise
		memtoReg = 1'b0;
		iorD = 1'b0;
		regDst = 2'd0;
		pcSrc = 2'd0;
		aluSrcA = 2'd0;
		aluSrcB = 2'd0;
		branch = 2'b00;
		irWrite = 1'b0;
		memWrite = 1'b0;
		pcWrite = 1'b0;
		regWrite = 1'b0;
		extOp = 1'b1;
		aluOp = aluAdd;
		case (state)
			stFetch: begin
				// PC + 4 straight back into the PC
				aluSrcB = 2'd1;
				irWrite = 1'b1;
				pcWrite = 1'b1;
			end
			stDecode: begin
				// Branch target into aluOut
				aluSrcB = 2'd3;
			end
			stMemAdr: begin
				aluSrcA = 2'd1;
				aluSrcB = 2'd2;
			end
			stMemRead: iorD = 1'b1;
			stMemWriteback: begin
				memtoReg = 1'b1;
				regWrite = 1'b1;
			end
			stMemWrite: begin
				iorD = 1'b1;
				memWrite = 1'b1;
			end
			stExecute: begin
				aluSrcA = isShift ? 2'd2 : 2'd1;
				aluOp = aluFunct;
			end
			stAluWriteback: begin
				regDst = 2'd1;
				regWrite = 1'b1;
			end
			stBranch: begin
				pcSrc = 2'd1;
				aluSrcA = 2'd1;
				aluOp = aluSub;
				branch = {opcode == opBne, opcode == opBeq};
			end
			stItypeExecute: begin
				aluSrcA = 2'd1;
				aluSrcB = 2'd2;
				aluOp = aluImm;
				// Logical immediates are zero extended
				extOp = !(opcode == opAndi || opcode == opOri || opcode == opXori);
			end
			stItypeWriteback: regWrite = 1'b1;
			stJump: begin
				pcSrc = 2'd2;
				pcWrite = 1'b1;
			end
			stJr: begin
				pcSrc = 2'd3;
				pcWrite = 1'b1;
			end
			stJal: begin
				pcSrc = 2'd2;
				pcWrite = 1'b1;
				regDst = 2'd2;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
	parameter logic [mipsPkg::dataWidth-1:0] resetVector = '0
) (
	input logic cclk,
	input logic rstb,
	input logic [mipsPkg::dataWidth-1:0] memRdata,
	input logic memtoReg,
	input logic iorD,
	input logic [1:0] regDst,
	input logic [1:0] pcSrc,
	input logic [1:0] aluSrcA,
	input logic [1:0] aluSrcB,
	input logic [1:0] branch,
	input logic irWrite,
	input logic pcWrite,
	input logic regWrite,
	input logic extOp,
	input mipsPkg::aluCtrlT aluControl,
	output logic [mipsPkg::dataWidth-1:0] instr,
	output logic [mipsPkg::dataWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWdata
);

	import mipsPkg::*;

	logic [dataWidth-1:0] pc, pcNext, mdr, regA, regB, aluOut;
	logic [dataWidth-1:0] readData1, readData2, writeData;
	logic [dataWidth-1:0] extImm, jumpTarget, srcA, srcB, aluResult;
	logic [regAddrWidth-1:0] writeAddr;
	logic zero;
	logic pcEn;

	assign pcEn = pcWrite | (branch[0] & zero) | (branch[1] & ~zero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= resetVector;
			instr <= '0;
		end else begin
			if (pcEn) begin
				pc <= pcNext;
			end
			if (irWrite) begin
				instr <= memRdata;
			end
		end
	end

	// Per-cycle holding registers between states
	always_ff @(posedge cclk) begin
		mdr <= memRdata;
		regA <= readData1;
		regB <= readData2;
		aluOut <= aluResult;
	end

	assign memAddr = iorD ? aluOut : pc;
	assign memWdata = regB;

	assign extImm = {{16{extOp & instr[15]}}, instr[15:0]};
	// PC already holds PC+4 here
	assign jumpTarget = {pc[31:28], instr[25:0], 2'b00};

	// jal stores the return address from the PC
	assign writeAddr = (regDst == 2'd2) ? 5'd31 : (regDst == 2'd1) ? instr[15:11] : instr[20:16];
	assign writeData = (regDst == 2'd2) ? pc : memtoReg ? mdr : aluOut;

	always_comb begin
		case (aluSrcA)
			2'd1: srcA = regA;
			2'd2: srcA = {{(dataWidth - 5){1'b0}}, instr[10:6]};
			default: srcA = pc;
		endcase
		case (aluSrcB)
			2'd0: srcB = regB;
			2'd1: srcB = 32'd4;
			2'd2: srcB = extImm;
			default: srcB = {extImm[dataWidth-3:0], 2'b00};
		endcase
		case (pcSrc)
			2'd1: pcNext = aluOut;
			2'd2: pcNext = jumpTarget;
			2'd3: pcNext = regA;
			default: pcNext = aluResult;
		endcase
	end

	registerFile regFile0 (
		.cclk(cclk),
		.rstb(rstb),
		.regWrite(regWrite),
		.readAddr1(instr[25:21]),
		.readAddr2(instr[20:16]),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	alu alu0 (
		.a(srcA),
		.b(srcB),
		.shamt(instr[10:6]),
		.aluControl(aluControl),
		.result(aluResult),
		.zero(zero)
	);

endmodule

`default_nettype wire

//--- verilog/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
	parameter logic [mipsPkg::dataWidth-1:0] resetVector = '0
) (
	input logic cclk,
	input logic rstb,
	input logic [mipsPkg::dataWidth-1:0] memRdata,
	output logic [mipsPkg::dataWidth-1:0] memAddr,
	output logic [mipsPkg::dataWidth-1:0] memWdata,
	output logic memWrite
);

	import mipsPkg::*;

	logic [dataWidth-1:0] instr;
	logic memtoReg, iorD, irWrite, pcWrite, regWrite, extOp;
	logic [1:0] regDst, pcSrc, aluSrcA, aluSrcB, branch;
	aluCtrlT aluControl;

	controlUnit ctrl0 (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.memtoReg(memtoReg),
		.iorD(iorD),
		.regDst(regDst),
		.pcSrc(pcSrc),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.branch(branch),
		.irWrite(irWrite),
		.memWrite(memWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.extOp(extOp),
		.aluControl(aluControl)
	);

	datapath #(
		.resetVector(resetVector)
	) dp0 (
		.cclk(cclk),
		.rstb(rstb),
		.memRdata(memRdata),
		.memtoReg(memtoReg),
		.iorD(iorD),
		.regDst(regDst),
		.pcSrc(pcSrc),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.branch(branch),
		.irWrite(irWrite),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.extOp(extOp),
		.aluControl(aluControl),
		.instr(instr),
		.memAddr(memAddr),
		.memWdata(memWdata)
	);

endmodule

`default_nettype wire

//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// Multicycle controller states
	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stMemAdr,
		stMemRead,
		stMemWriteback,
		stMemWrite,
		stExecute,
		stAluWriteback,
		stBranch,
		stItypeExecute,
		stItypeWriteback,
		stJump,
		stJr,
		stJal
	} ctrlState;

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opJ = 6'h02,
		opJal = 6'h03,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddi = 6'h08,
		opSlti = 6'h0a,
		opAndi = 6'h0c,
		opOri = 6'h0d,
		opXori = 6'h0e,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnSra = 6'h03,
		fnJr = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnXor = 6'h26,
		fnNor = 6'h27,
		fnSlt = 6'h2a
	} functT;

	// Operation class from controller to ALU decoder
	typedef enum logic [1:0] {
		aluAdd = 2'd0,
		aluSub = 2'd1,
		aluFunct = 2'd2,
		aluImm = 2'd3
	} aluOpT;

	typedef enum logic [3:0] {
		acAdd,
		acSub,
		acAnd,
		acOr,
		acXor,
		acNor,
		acSlt,
		acSll,
		acSrl,
		acSra,
		acLui
	} aluCtrlT;

endpackage

`default_nettype wire

//--- verilog/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic cclk,
	input logic rstb,
	input logic regWrite,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr1,
	input logic [mipsPkg::regAddrWidth-1:0] readAddr2,
	input logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	output logic [mipsPkg::dataWidth-1:0] readData1,
	output logic [mipsPkg::dataWidth-1:0] readData2
);

	import mipsPkg::*;

	logic [dataWidth-1:0] regs [2**regAddrWidth];

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// r0 is hardwired
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire
